/* hw/gshare_config.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizing of the gshare predictor. PHT_INDEX_BITS must be at least
// HISTORY_BITS, and PHT_QUEUE_DEPTH must be 2 or more.
// Instructions are assumed 4-byte aligned (INSN_ADDR_SHIFT of 2).
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef GSHARE_CONFIG_SVH
`define GSHARE_CONFIG_SVH

// Slots predicted and branches resolved per cycle.
`define FETCH_WIDTH 2
`define RESOLVE_WIDTH 2

// Pattern history table and global history sizing.
`define PHT_INDEX_BITS 6
`define HISTORY_BITS 4
`define PHT_QUEUE_DEPTH 4

// Address layout.
`define ADDR_BITS 32
`define INSN_ADDR_SHIFT 2
`define BTB_INDEX_BITS 4

`endif

/* hw/BranchPredTypes.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by the gshare predictor and its execute-side users.
// Counters are 2-bit saturating, MSB set means taken.
// History holds the newest outcome in the LSB.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "gshare_config.svh"

package BranchPredTypes;

    typedef logic [`PHT_INDEX_BITS-1:0] PhtIndex;
    typedef logic [1:0] PhtCounter;
    typedef logic [`HISTORY_BITS-1:0] GlobalHistory;
    typedef logic [`ADDR_BITS-1:0] InsnAddr;

    // BTB addressing, tag is whatever lies above the index.
    typedef logic [`BTB_INDEX_BITS-1:0] BtbIndex;
    typedef logic [`ADDR_BITS-`INSN_ADDR_SHIFT-`BTB_INDEX_BITS-1:0] BtbTag;

    // One counter write into the PHT.
    typedef struct packed {
        PhtIndex addr;
        PhtCounter value;
    } PhtWrite;

    typedef struct packed {
        logic valid;
        InsnAddr pc;
    } FetchRequest;

    // Per-slot result, history is the one the counter was read with.
    typedef struct packed {
        logic btbHit;
        logic taken;
        PhtCounter counter;
        GlobalHistory history;
    } SlotPrediction;

    // Counter and history come back exactly as they were predicted.
    typedef struct packed {
        logic valid;
        InsnAddr addr;
        logic isCondBr;
        logic execTaken;
        logic mispred;
        PhtCounter counter;
        GlobalHistory history;
    } BranchResolve;

endpackage

/* hw/PhtBankedRam.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pattern history counters, one registered read per fetch slot and a
// single write port. A read of an address written in the same cycle
// returns the old counter.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "gshare_config.svh"

module PhtBankedRam (
    input  logic                      clk,
    input  logic                      rstN,
    input  BranchPredTypes::PhtIndex  readAddr [`FETCH_WIDTH],
    output BranchPredTypes::PhtCounter readData [`FETCH_WIDTH],
    input  logic                      writeEn,
    input  BranchPredTypes::PhtWrite  writeReq
);

    localparam int Entries = 1 << `PHT_INDEX_BITS;

    BranchPredTypes::PhtCounter counters [Entries];

    // Contents are set by the sweep after reset.
    always_ff @(posedge clk) begin
        if (writeEn) begin
            counters[writeReq.addr] <= writeReq.value;
        end
    end

    // Read ports, one per slot.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                readData[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                readData[i] <= counters[readAddr[i]];
            end
        end
    end

endmodule

/* hw/PhtUpdateQueue.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Deferred PHT writes. popData shows the oldest entry combinationally.
// A push into a full queue without a pop is dropped, which only costs
// training. A pop of an empty queue is ignored.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "gshare_config.svh"

module PhtUpdateQueue (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     push,
    input  BranchPredTypes::PhtWrite pushData,
    input  logic                     pop,
    output BranchPredTypes::PhtWrite popData,
    output logic                     full,
    output logic                     empty
);

    localparam int Depth = `PHT_QUEUE_DEPTH;
    localparam int PtrBits = $clog2(Depth);

    BranchPredTypes::PhtWrite entries [Depth];
    logic [PtrBits-1:0] headPtr;
    logic [PtrBits-1:0] tailPtr;
    logic [PtrBits:0] count;
    logic doPush;
    logic doPop;

    function automatic logic [PtrBits-1:0] nextPtr(input logic [PtrBits-1:0] ptr);
        return (ptr == PtrBits'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == (PtrBits + 1)'(Depth));
    assign empty = (count == '0);
    assign doPop = pop && !empty;
    // A pop frees the slot, so a full queue still takes a push then.
    assign doPush = push && (!full || doPop);
    assign popData = entries[tailPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[headPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                headPtr <= nextPtr(headPtr);
            end
            if (doPop) begin
                tailPtr <= nextPtr(tailPtr);
            end
            case ({doPush, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/BranchTargetBuffer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped table telling which fetch slots hold known branches.
// Any valid resolve installs its entry, also during the PHT sweep.
// Results are registered to line up with the PHT read data.
// An invalid fetch reports no hits.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "gshare_config.svh"

module BranchTargetBuffer (
    input  logic                          clk,
    input  logic                          rstN,
    input  BranchPredTypes::FetchRequest  fetchReq,
    input  BranchPredTypes::BranchResolve resolveIn [`RESOLVE_WIDTH],
    output logic                          slotHit [`FETCH_WIDTH],
    output logic                          slotIsCondBr [`FETCH_WIDTH]
);

    localparam int Entries = 1 << `BTB_INDEX_BITS;
    localparam int TagLsb = `INSN_ADDR_SHIFT + `BTB_INDEX_BITS;

    logic [Entries-1:0] entryValid;
    BranchPredTypes::BtbTag entryTag [Entries];
    logic entryIsCondBr [Entries];

    BranchPredTypes::InsnAddr slotAddr [`FETCH_WIDTH];
    BranchPredTypes::BtbIndex slotIndex [`FETCH_WIDTH];
    BranchPredTypes::BtbIndex resolveIndex [`RESOLVE_WIDTH];

    always_comb begin
        // Slot i sits i instructions after the fetch PC.
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            slotAddr[i] = fetchReq.pc + BranchPredTypes::InsnAddr'(i << `INSN_ADDR_SHIFT);
            slotIndex[i] = slotAddr[i][`INSN_ADDR_SHIFT +: `BTB_INDEX_BITS];
        end
        for (int i = 0; i < `RESOLVE_WIDTH; i++) begin
            resolveIndex[i] = resolveIn[i].addr[`INSN_ADDR_SHIFT +: `BTB_INDEX_BITS];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                slotHit[i] <= 1'b0;
                slotIsCondBr[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                slotHit[i] <= fetchReq.valid && entryValid[slotIndex[i]] &&
                    (entryTag[slotIndex[i]] == slotAddr[i][`ADDR_BITS-1:TagLsb]);
                slotIsCondBr[i] <= entryIsCondBr[slotIndex[i]];
            end
        end
    end

    // Later lanes are written last, so lane 1 wins a shared entry.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            entryValid <= '0;
        end else begin
            for (int i = 0; i < `RESOLVE_WIDTH; i++) begin
                if (resolveIn[i].valid) begin
                    entryValid[resolveIndex[i]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RESOLVE_WIDTH; i++) begin
            if (resolveIn[i].valid) begin
                entryTag[resolveIndex[i]] <= resolveIn[i].addr[`ADDR_BITS-1:TagLsb];
                entryIsCondBr[resolveIndex[i]] <= resolveIn[i].isCondBr;
            end
        end
    end

endmodule

/* hw/GshareCore.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Gshare control. Predictions come one cycle after the fetch PC.
// The first valid resolve writes the PHT directly, a second one goes
// to the update queue and is lost if the queue is full.
// Resolves are ignored until the reset sweep has finished.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "gshare_config.svh"

module GshareCore (
    input  logic                           clk,
    input  logic                           rstN,
    input  BranchPredTypes::FetchRequest   fetchReq,
    input  BranchPredTypes::BranchResolve  resolveIn [`RESOLVE_WIDTH],
    input  logic                           btbHit [`FETCH_WIDTH],
    input  logic                           btbIsCondBr [`FETCH_WIDTH],
    output BranchPredTypes::PhtIndex       phtReadAddr [`FETCH_WIDTH],
    input  BranchPredTypes::PhtCounter     phtReadData [`FETCH_WIDTH],
    output logic                           phtWriteEn,
    output BranchPredTypes::PhtWrite       phtWrite,
    output logic                           queuePush,
    output BranchPredTypes::PhtWrite       queuePushData,
    output logic                           queuePop,
    input  BranchPredTypes::PhtWrite       queueData,
    input  logic                           queueEmpty,
    input  logic                           queueFull,
    output BranchPredTypes::SlotPrediction predOut [`FETCH_WIDTH],
    output logic                           predReady
);

    localparam BranchPredTypes::PhtCounter WeakTaken = 2'd2;

    // History that the current predOut group was read with.
    BranchPredTypes::GlobalHistory historyReg;
    BranchPredTypes::GlobalHistory nextHistory;
    BranchPredTypes::PhtIndex sweepIdx;
    logic readyReg;
    logic slotTaken [`FETCH_WIDTH];
    logic groupBlocked;

    logic laneValid [`RESOLVE_WIDTH];
    BranchPredTypes::PhtWrite laneWrite [`RESOLVE_WIDTH];
    logic directValid;
    BranchPredTypes::PhtWrite directWrite;
    logic pushValid;

    // Address bits above the byte offset, history folded into the top.
    function automatic BranchPredTypes::PhtIndex hashIndex(
        input BranchPredTypes::InsnAddr addr,
        input BranchPredTypes::GlobalHistory hist
    );
        BranchPredTypes::PhtIndex idx;
        idx = addr[`INSN_ADDR_SHIFT +: `PHT_INDEX_BITS];
        idx[`PHT_INDEX_BITS-1 -: `HISTORY_BITS] = idx[`PHT_INDEX_BITS-1 -: `HISTORY_BITS] ^ hist;
        return idx;
    endfunction

    function automatic BranchPredTypes::PhtCounter trainCounter(
        input BranchPredTypes::PhtCounter ctr,
        input logic taken
    );
        if (taken) begin
            return (ctr == 2'd3) ? 2'd3 : ctr + 1'b1;
        end
        return (ctr == 2'd0) ? 2'd0 : ctr - 1'b1;
    endfunction

    assign predReady = readyReg;

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            slotTaken[i] = phtReadData[i][1] && btbHit[i];
            predOut[i].btbHit = btbHit[i];
            predOut[i].taken = slotTaken[i];
            predOut[i].counter = phtReadData[i];
            predOut[i].history = historyReg;
        end
    end

    // Next history, then the read addresses for the incoming fetch PC.
    always_comb begin
        nextHistory = historyReg;
        groupBlocked = 1'b0;
        // Slots behind a predicted-taken branch are not executed.
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (!groupBlocked && btbHit[i] && btbIsCondBr[i]) begin
                nextHistory = {nextHistory[`HISTORY_BITS-2:0], slotTaken[i]};
                groupBlocked = slotTaken[i];
            end
        end
        // Recovery overrides fetch updates, the last lane wins.
        for (int i = 0; i < `RESOLVE_WIDTH; i++) begin
            if (laneValid[i] && resolveIn[i].mispred) begin
                if (resolveIn[i].isCondBr) begin
                    nextHistory = {resolveIn[i].history[`HISTORY_BITS-2:0],
                                   resolveIn[i].execTaken};
                end else begin
                    nextHistory = resolveIn[i].history;
                end
            end
        end
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            phtReadAddr[i] = hashIndex(
                fetchReq.pc + BranchPredTypes::InsnAddr'(i << `INSN_ADDR_SHIFT),
                nextHistory);
        end
    end

    always_comb begin
        for (int i = 0; i < `RESOLVE_WIDTH; i++) begin
            laneValid[i] = readyReg && resolveIn[i].valid;
            laneWrite[i].addr = hashIndex(resolveIn[i].addr, resolveIn[i].history);
            laneWrite[i].value = trainCounter(resolveIn[i].counter, resolveIn[i].execTaken);
        end
    end

    // Write port arbitration. Sweep, then direct write, then queue drain.
    always_comb begin
        directValid = 1'b0;
        directWrite = '0;
        pushValid = 1'b0;
        queuePushData = '0;
        for (int i = 0; i < `RESOLVE_WIDTH; i++) begin
            if (laneValid[i]) begin
                if (!directValid) begin
                    directValid = 1'b1;
                    directWrite = laneWrite[i];
                end else if (!pushValid) begin
                    pushValid = 1'b1;
                    queuePushData = laneWrite[i];
                end
            end
        end
        queuePush = pushValid && !queueFull;
        queuePop = readyReg && !directValid && !queueEmpty;

        if (!readyReg) begin
            phtWriteEn = 1'b1;
            phtWrite.addr = sweepIdx;
            phtWrite.value = WeakTaken;
        end else if (directValid) begin
            phtWriteEn = 1'b1;
            phtWrite = directWrite;
        end else begin
            phtWriteEn = queuePop;
            phtWrite = queueData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            historyReg <= '0;
            sweepIdx <= '0;
            readyReg <= 1'b0;
        end else begin
            historyReg <= nextHistory;
            if (!readyReg) begin
                sweepIdx <= sweepIdx + 1'b1;
                if (sweepIdx == '1) begin
                    readyReg <= 1'b1;
                end
            end
        end
    end

endmodule

/* hw/BranchPredictor.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-wide gshare direction predictor. Fixed one-cycle prediction
// latency, no back-pressure on any port. predReady stays low for the
// PHT sweep that follows reset.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "gshare_config.svh"

module BranchPredictor (
    input  logic                           clk,
    input  logic                           rstN,
    input  BranchPredTypes::FetchRequest   fetchReq,
    input  BranchPredTypes::BranchResolve  resolveIn [`RESOLVE_WIDTH],
    output BranchPredTypes::SlotPrediction predOut [`FETCH_WIDTH],
    output logic                           predReady
);

    BranchPredTypes::PhtIndex phtReadAddr [`FETCH_WIDTH];
    BranchPredTypes::PhtCounter phtReadData [`FETCH_WIDTH];
    logic phtWriteEn;
    BranchPredTypes::PhtWrite phtWrite;
    logic queuePush;
    logic queuePop;
    BranchPredTypes::PhtWrite queuePushData;
    BranchPredTypes::PhtWrite queueData;
    logic queueFull;
    logic queueEmpty;
    logic btbHit [`FETCH_WIDTH];
    logic btbIsCondBr [`FETCH_WIDTH];

    GshareCore core (
        .clk(clk), .rstN(rstN), .fetchReq(fetchReq), .resolveIn(resolveIn),
        .btbHit(btbHit), .btbIsCondBr(btbIsCondBr),
        .phtReadAddr(phtReadAddr), .phtReadData(phtReadData),
        .phtWriteEn(phtWriteEn), .phtWrite(phtWrite),
        .queuePush(queuePush), .queuePushData(queuePushData), .queuePop(queuePop),
        .queueData(queueData), .queueEmpty(queueEmpty), .queueFull(queueFull),
        .predOut(predOut), .predReady(predReady)
    );

    PhtBankedRam phtRam (
        .clk(clk), .rstN(rstN), .readAddr(phtReadAddr), .readData(phtReadData),
        .writeEn(phtWriteEn), .writeReq(phtWrite)
    );

    PhtUpdateQueue updateQueue (
        .clk(clk), .rstN(rstN), .push(queuePush), .pushData(queuePushData),
        .pop(queuePop), .popData(queueData), .full(queueFull), .empty(queueEmpty)
    );

    BranchTargetBuffer btb (
        .clk(clk), .rstN(rstN), .fetchReq(fetchReq), .resolveIn(resolveIn),
        .slotHit(btbHit), .slotIsCondBr(btbIsCondBr)
    );

endmodule

/* verif/BranchPredictorTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the gshare predictor. The reference model tracks the
// counters, history, BTB and deferred write queue cycle by cycle.
// Inputs change and predictions are checked on the falling edge.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "gshare_config.svh"

module BranchPredictorTb;

    logic clk;
    logic rstN;
    BranchPredTypes::FetchRequest fetchReq;
    BranchPredTypes::BranchResolve resolveIn [`RESOLVE_WIDTH];
    BranchPredTypes::SlotPrediction predOut [`FETCH_WIDTH];
    logic predReady;

    // Reference model state.
    BranchPredTypes::PhtCounter modelCtr [1 << `PHT_INDEX_BITS];
    BranchPredTypes::GlobalHistory modelHist;
    BranchPredTypes::PhtWrite modelQueue [$];
    logic btbValid [1 << `BTB_INDEX_BITS];
    logic btbCond [1 << `BTB_INDEX_BITS];
    BranchPredTypes::InsnAddr btbAddr [1 << `BTB_INDEX_BITS];

    BranchPredTypes::SlotPrediction expPred [`FETCH_WIDTH];
    BranchPredTypes::SlotPrediction seenPred [`FETCH_WIDTH];
    logic expCond [`FETCH_WIDTH];
    logic expValid;
    int checks;
    int errors;

    BranchPredictor UUT (
        .clk(clk), .rstN(rstN), .fetchReq(fetchReq), .resolveIn(resolveIn),
        .predOut(predOut), .predReady(predReady)
    );

    always #50 clk = ~clk;

    // Instruction address bits with the history folded into the top of the index.
    function automatic BranchPredTypes::PhtIndex pcHash(input BranchPredTypes::InsnAddr addr,
                                                        input BranchPredTypes::GlobalHistory hist);
        return BranchPredTypes::PhtIndex'(addr >> `INSN_ADDR_SHIFT) ^
               (BranchPredTypes::PhtIndex'(hist) << (`PHT_INDEX_BITS - `HISTORY_BITS));
    endfunction

    function automatic BranchPredTypes::PhtCounter saturate(input BranchPredTypes::PhtCounter c,
                                                            input logic up);
        return up ? ((c == 2'd3) ? c : c + 2'd1) : ((c == 2'd0) ? c : c - 2'd1);
    endfunction

    function automatic int btbSlot(input BranchPredTypes::InsnAddr addr);
        return int'(addr[`INSN_ADDR_SHIFT +: `BTB_INDEX_BITS]);
    endfunction

    function automatic BranchPredTypes::FetchRequest fetchAt(input BranchPredTypes::InsnAddr addr);
        return '{valid: 1'b1, pc: addr};
    endfunction

    // Counter and history come from the prediction, as in a real pipeline.
    function automatic BranchPredTypes::BranchResolve resolveOf(
        input BranchPredTypes::InsnAddr addr, input logic isCond, input logic taken,
        input BranchPredTypes::SlotPrediction pred);
        return '{valid: 1'b1, addr: addr, isCondBr: isCond, execTaken: taken,
                 mispred: taken != pred.taken, counter: pred.counter, history: pred.history};
    endfunction

    task automatic checkPredictions();
        checks++;
        assert (predReady) else begin
            errors++;
            $display("error at %0t ns: predReady dropped after the sweep", $time);
        end
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            checks++;
            assert (predOut[i] == expPred[i]) else begin
                errors++;
                $display("error at %0t ns: slot %0d predicted %h, model expects %h",
                         $time, i, predOut[i], expPred[i]);
            end
        end
    endtask

    task automatic stepCycle(input BranchPredTypes::FetchRequest fetch,
                             input BranchPredTypes::BranchResolve res0,
                             input BranchPredTypes::BranchResolve res1);
        BranchPredTypes::BranchResolve res [`RESOLVE_WIDTH];
        BranchPredTypes::GlobalHistory nextHist;
        BranchPredTypes::InsnAddr addr;
        BranchPredTypes::PhtWrite w;
        logic blocked;
        logic direct;
        int b;
        @(negedge clk);
        if (expValid) begin
            checkPredictions();
        end
        seenPred = predOut;
        res[0] = res0;
        res[1] = res1;
        // Predictions now on predOut shift in up to the first taken one.
        nextHist = modelHist;
        blocked = 1'b0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (!blocked && expPred[i].btbHit && expCond[i]) begin
                nextHist = {nextHist[`HISTORY_BITS-2:0], expPred[i].taken};
                blocked = expPred[i].taken;
            end
        end
        // Recovery overrides them and a later lane goes last.
        for (int i = 0; i < `RESOLVE_WIDTH; i++) begin
            if (res[i].valid && res[i].mispred) begin
                nextHist = res[i].isCondBr ?
                    {res[i].history[`HISTORY_BITS-2:0], res[i].execTaken} : res[i].history;
            end
        end
        // Lookups see the tables as they were before this cycle's writes.
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            addr = fetch.pc + BranchPredTypes::InsnAddr'(i * 4);
            b = btbSlot(addr);
            expPred[i].btbHit = fetch.valid && btbValid[b] &&
                (btbAddr[b][`ADDR_BITS-1:`INSN_ADDR_SHIFT] == addr[`ADDR_BITS-1:`INSN_ADDR_SHIFT]);
            expPred[i].counter = modelCtr[pcHash(addr, nextHist)];
            expPred[i].taken = expPred[i].btbHit && expPred[i].counter[1];
            expPred[i].history = nextHist;
            expCond[i] = btbCond[b];
        end
        // The first valid lane trains at once. A second one waits in the queue.
        direct = 1'b0;
        for (int i = 0; i < `RESOLVE_WIDTH; i++) begin
            if (res[i].valid) begin
                w.addr = pcHash(res[i].addr, res[i].history);
                w.value = saturate(res[i].counter, res[i].execTaken);
                if (!direct) begin
                    modelCtr[w.addr] = w.value;
                end else if (modelQueue.size() < `PHT_QUEUE_DEPTH) begin
                    modelQueue.push_back(w);
                end
                direct = 1'b1;
                b = btbSlot(res[i].addr);
                btbValid[b] = 1'b1;
                btbCond[b] = res[i].isCondBr;
                btbAddr[b] = res[i].addr;
            end
        end
        if (!direct && modelQueue.size() > 0) begin
            w = modelQueue.pop_front();
            modelCtr[w.addr] = w.value;
        end
        modelHist = nextHist;
        expValid = 1'b1;
        fetchReq = fetch;
        resolveIn[0] = res0;
        resolveIn[1] = res1;
    endtask

    task automatic trainBranch(input BranchPredTypes::InsnAddr pc, input logic taken);
        stepCycle(fetchAt(pc), '0, '0);
        stepCycle(fetchAt(pc), '0, '0);
        // SeenPred holds the first fetch's prediction here.
        stepCycle(fetchAt(pc), resolveOf(pc, 1'b1, taken, seenPred[0]), '0);
    endtask

    task automatic runDirected();
        BranchPredTypes::SlotPrediction fresh;
        logic seen;
        fresh = '{btbHit: 1'b0, taken: 1'b0, counter: 2'd2, history: '0};
        // Two conditional branches of one fetch group are installed together.
        stepCycle('0, resolveOf(32'h100, 1'b1, 1'b0, fresh), resolveOf(32'h104, 1'b1, 1'b0, fresh));
        for (int k = 0; k < 4; k++) begin
            stepCycle(fetchAt(32'h100), '0, '0);
        end
        // Saturate upward, then downward with mispredictions.
        stepCycle('0, resolveOf(32'h140, 1'b1, 1'b1, fresh), '0);
        for (int k = 0; k < 12; k++) begin
            trainBranch(32'h140, k < 6);
        end
        // Both lanes mispredict. Lane 1 restores history 0 and is queued.
        stepCycle('0, resolveOf(32'h300, 1'b1, 1'b1, fresh), resolveOf(32'h344, 1'b0, 1'b1, fresh));
        seen = 1'b0;
        for (int n = 0; n < 20 && !seen; n++) begin
            stepCycle(fetchAt(32'h344), '0, '0);
            seen = seenPred[0].btbHit && seenPred[0].counter == 2'd3;
        end
        assert (seen) else begin
            errors++;
            $display("Queued counter update of lane 1 never appeared in predictions");
        end
    endtask

    task automatic runRandom();
        BranchPredTypes::FetchRequest fetch;
        BranchPredTypes::BranchResolve res [`RESOLVE_WIDTH];
        BranchPredTypes::InsnAddr lastPc;
        BranchPredTypes::InsnAddr predPc;
        lastPc = '0;
        predPc = '0;
        for (int k = 0; k < 600; k++) begin
            fetch = fetchAt(32'h2000 + BranchPredTypes::InsnAddr'(($urandom % 40) * 4));
            fetch.valid = ($urandom % 4) != 0;
            for (int i = 0; i < `RESOLVE_WIDTH; i++) begin
                res[i] = '0;
                if (seenPred[i].btbHit || ($urandom % 4) == 0) begin
                    res[i] = resolveOf(predPc + BranchPredTypes::InsnAddr'(i * 4),
                                       ($urandom % 4) != 0, 1'($urandom), seenPred[i]);
                end
            end
            stepCycle(fetch, res[0], res[1]);
            predPc = lastPc;
            lastPc = fetch.pc;
        end
    endtask

    initial begin
        int n;
        void'($urandom(32'h1272_a4ce));
        clk = 1'b0;
        rstN = 1'b0;
        fetchReq = '0;
        resolveIn[0] = '0;
        resolveIn[1] = '0;
        checks = 0;
        errors = 0;
        expValid = 1'b0;
        modelHist = '0;
        for (int i = 0; i < (1 << `PHT_INDEX_BITS); i++) begin
            modelCtr[i] = 2'd2;
        end
        for (int i = 0; i < (1 << `BTB_INDEX_BITS); i++) begin
            btbValid[i] = 1'b0;
            btbCond[i] = 1'b0;
            btbAddr[i] = '0;
        end
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            expPred[i] = '0;
            seenPred[i] = '0;
            expCond[i] = 1'b0;
        end
        repeat (16) @(negedge clk);
        rstN = 1'b1;
        // The sweep takes one cycle per PHT entry.
        n = 0;
        while (!predReady && n < 4 * (1 << `PHT_INDEX_BITS)) begin
            @(negedge clk);
            n++;
        end
        if (!predReady) begin
            errors++;
            $display("predReady never rose after the PHT sweep");
        end else begin
            runDirected();
            runRandom();
        end
        $display("Closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+hw
hw/BranchPredTypes.sv
hw/PhtBankedRam.sv
hw/PhtUpdateQueue.sv
hw/BranchTargetBuffer.sv
hw/GshareCore.sv
hw/BranchPredictor.sv
verif/BranchPredictorTb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the gshare predictor testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module BranchPredictorTb -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression passed" <<< "$output"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
